//--- design/aes_ctr_pkg.sv
//////////////////////////////////////////////////////////////////////
// AES CTR mode counter definitions
// Slice sizes, rail patterns and the sparse state encoding shared by
// the counter increment blocks
//////////////////////////////////////////////////////////////////////

package aes_ctr_pkg;

  //////////////////////////////////////////////////////////////////////
  // Counter geometry
  //////////////////////////////////////////////////////////////////////

  // Full counter width, one AES block
  localparam int unsigned CtrWidth      = 128;
  // Bits handled per clock cycle
  localparam int unsigned SliceSizeCtr  = 16;
  // Slices per counter
  localparam int unsigned NumSlicesCtr  = CtrWidth / SliceSizeCtr;
  // Index width, enough for NumSlicesCtr slices
  localparam int unsigned SliceIdxWidth = 3;

  //////////////////////////////////////////////////////////////////////
  // Increment request rails
  //////////////////////////////////////////////////////////////////////

  localparam int unsigned IncrRailWidth = 3;

  // Request an increment, every rail high
  localparam logic [IncrRailWidth-1:0] IncrRailOn  = {IncrRailWidth{1'b1}};
  // Idle, every rail low
  localparam logic [IncrRailWidth-1:0] IncrRailOff = {IncrRailWidth{1'b0}};

  //////////////////////////////////////////////////////////////////////
  // Counter FSM states
  //////////////////////////////////////////////////////////////////////

  // Sparse encoding, pairwise Hamming distance of at least 3
  // All other 6-bit values are illegal and lead to CTR_ERROR
  typedef enum logic [5:0] {
    CTR_IDLE  = 6'b001011,
    CTR_INCR  = 6'b110100,
    CTR_ERROR = 6'b010111
  } aes_ctr_e;

endpackage

//--- design/aes_ctr_rail_dec.sv
//////////////////////////////////////////////////////////////////////
// AES CTR increment rail decoder
// Turns the three-rail request into a strobe and an encoding error
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module aes_ctr_rail_dec (
  input  logic [aes_ctr_pkg::IncrRailWidth-1:0] incr_rail_i,
  output logic                                  incr_o,
  output logic                                  incr_err_o
);

  import aes_ctr_pkg::*;

  // Pattern matches
  logic rail_on;
  logic rail_off;

  //////////////////////////////////////////////////////////////////////
  // Decode
  //////////////////////////////////////////////////////////////////////

  // All rails high
  assign rail_on  = (incr_rail_i == IncrRailOn);
  // All rails low
  assign rail_off = (incr_rail_i == IncrRailOff);

  // Increment only on the full pattern
  // A single flipped rail never looks like a request
  assign incr_o = rail_on;

  // Mixed rails are a fault, idle or glitch alike
  assign incr_err_o = ~rail_on & ~rail_off;

endmodule

//--- design/aes_ctr_fsm.sv
//////////////////////////////////////////////////////////////////////
// AES CTR increment FSM
// Adds one to the counter one slice per cycle with a rippled carry,
// locks into a terminal error state on any fault
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module aes_ctr_fsm (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,

  // Request and fault inputs
  input  logic                                  incr_i,
  input  logic                                  incr_err_i,
  input  logic                                  mr_err_i,

  // Status
  output logic                                  ready_o,
  output logic                                  alert_o,

  // Slice access to the counter storage
  output logic [aes_ctr_pkg::SliceIdxWidth-1:0] ctr_slice_idx_o,
  input  logic [aes_ctr_pkg::SliceSizeCtr-1:0]  ctr_slice_i,
  output logic [aes_ctr_pkg::SliceSizeCtr-1:0]  ctr_slice_o,
  output logic                                  ctr_we_o
);

  import aes_ctr_pkg::*;

  // State
  aes_ctr_e                 aes_ctr_ns;
  aes_ctr_e                 aes_ctr_cs;

  // Slice pointer and carry
  logic [SliceIdxWidth-1:0] ctr_slice_idx_d;
  logic [SliceIdxWidth-1:0] ctr_slice_idx_q;
  logic                     ctr_carry_d;
  logic                     ctr_carry_q;

  // Slice sum, top bit is the carry out
  logic [SliceSizeCtr:0]    ctr_value;

  //////////////////////////////////////////////////////////////////////
  // Slice adder
  //////////////////////////////////////////////////////////////////////

  // Current slice plus incoming carry
  assign ctr_value   = {1'b0, ctr_slice_i} + {{SliceSizeCtr{1'b0}}, ctr_carry_q};
  assign ctr_slice_o = ctr_value[SliceSizeCtr-1:0];

  //////////////////////////////////////////////////////////////////////
  // Next state logic
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    // Default outputs
    ready_o         = 1'b0;
    ctr_we_o        = 1'b0;
    alert_o         = 1'b0;

    // Hold by default
    aes_ctr_ns      = aes_ctr_cs;
    ctr_slice_idx_d = ctr_slice_idx_q;
    ctr_carry_d     = ctr_carry_q;

    case (aes_ctr_cs)
      CTR_IDLE: begin
        ready_o = 1'b1;
        if (incr_i) begin
          // Start at slice 0, carry in of one
          ctr_slice_idx_d = '0;
          ctr_carry_d     = 1'b1;
          aes_ctr_ns      = CTR_INCR;
        end
      end

      CTR_INCR: begin
        // Write back this slice, pass carry out on
        ctr_we_o        = 1'b1;
        ctr_slice_idx_d = ctr_slice_idx_q + SliceIdxWidth'(1);
        ctr_carry_d     = ctr_value[SliceSizeCtr];
        // Last slice done, final carry dropped (mod 2^128)
        if (ctr_slice_idx_q == SliceIdxWidth'(NumSlicesCtr - 1)) begin
          aes_ctr_ns = CTR_IDLE;
        end
      end

      CTR_ERROR: begin
        // Terminal, only reset leaves
        alert_o = 1'b1;
      end

      default: begin
        // Illegal encoding, e.g. a fault on the state flops
        alert_o    = 1'b1;
        aes_ctr_ns = CTR_ERROR;
      end
    endcase

    // Faults override everything, from any state
    if (incr_err_i || mr_err_i) begin
      aes_ctr_ns = CTR_ERROR;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      aes_ctr_cs      <= CTR_IDLE;
      ctr_slice_idx_q <= '0;
      ctr_carry_q     <= 1'b0;
    end else begin
      aes_ctr_cs      <= aes_ctr_ns;
      ctr_slice_idx_q <= ctr_slice_idx_d;
      ctr_carry_q     <= ctr_carry_d;
    end
  end

  // Index straight from the flop
  assign ctr_slice_idx_o = ctr_slice_idx_q;

  //////////////////////////////////////////////////////////////////////
  // Assertions
  //////////////////////////////////////////////////////////////////////

  // No alert means a legal working state
  a_state_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !alert_o |-> aes_ctr_cs inside {CTR_IDLE, CTR_INCR});

  // Never writing the counter while advertising ready
  a_we_not_ready: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ctr_we_o |-> !ready_o);

  // Alert is sticky until reset
  a_alert_sticky: assert property (@(posedge clk_i) disable iff (!rst_ni)
    alert_o |=> alert_o);

endmodule

//--- design/aes_ctr_store.sv
//////////////////////////////////////////////////////////////////////
// AES CTR counter storage
// Eight slice registers with a full-width load and a slice port
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module aes_ctr_store (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,

  // Full-width load
  input  logic                                  load_i,
  input  logic [aes_ctr_pkg::CtrWidth-1:0]      load_value_i,

  // Slice read and write port
  input  logic [aes_ctr_pkg::SliceIdxWidth-1:0] slice_idx_i,
  input  logic                                  slice_we_i,
  input  logic [aes_ctr_pkg::SliceSizeCtr-1:0]  slice_wdata_i,
  output logic [aes_ctr_pkg::SliceSizeCtr-1:0]  slice_rdata_o,

  // Whole counter
  output logic [aes_ctr_pkg::CtrWidth-1:0]      ctr_o
);

  import aes_ctr_pkg::*;

  // Slice 0 holds the least significant bits
  logic [NumSlicesCtr-1:0][SliceSizeCtr-1:0] ctr_q;

  //////////////////////////////////////////////////////////////////////
  // Slice registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ctr_q <= '0;
    end else if (load_i) begin
      // Load replaces every slice
      ctr_q <= load_value_i;
    end else if (slice_we_i) begin
      // Only the addressed slice
      ctr_q[slice_idx_i] <= slice_wdata_i;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Read side
  //////////////////////////////////////////////////////////////////////

  // Slice mux on the index
  assign slice_rdata_o = ctr_q[slice_idx_i];

  // Packed slices form the counter directly
  assign ctr_o = ctr_q;

  //////////////////////////////////////////////////////////////////////
  // Assertions
  //////////////////////////////////////////////////////////////////////

  // A load during an increment would be lost in the slice write
  a_no_load_on_write: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(load_i && slice_we_i));

endmodule

//--- design/aes_ctr.sv
//////////////////////////////////////////////////////////////////////
// AES CTR counter increment top
// Rail decoder, slice-serial increment FSM and counter storage
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module aes_ctr (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,

  // Requests and faults
  input  logic [aes_ctr_pkg::IncrRailWidth-1:0] incr_rail_i,
  input  logic                                  mr_err_i,

  // Counter load
  input  logic                                  ctr_load_i,
  input  logic [aes_ctr_pkg::CtrWidth-1:0]      ctr_load_value_i,

  // Status and counter
  output logic                                  ready_o,
  output logic                                  alert_o,
  output logic [aes_ctr_pkg::CtrWidth-1:0]      ctr_o
);

  import aes_ctr_pkg::*;

  // Decoded request
  logic                     incr;
  logic                     incr_err;

  // FSM to storage slice port
  logic [SliceIdxWidth-1:0] ctr_slice_idx;
  logic                     ctr_we;
  logic [SliceSizeCtr-1:0]  ctr_slice_wdata;
  logic [SliceSizeCtr-1:0]  ctr_slice_rdata;

  // Rails to strobe
  aes_ctr_rail_dec u_rail_dec (
    .incr_rail_i (incr_rail_i),
    .incr_o      (incr),
    .incr_err_o  (incr_err)
  );

  // Increment control
  aes_ctr_fsm u_fsm (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .incr_i          (incr),
    .incr_err_i      (incr_err),
    .mr_err_i        (mr_err_i),
    .ready_o         (ready_o),
    .alert_o         (alert_o),
    .ctr_slice_idx_o (ctr_slice_idx),
    .ctr_slice_i     (ctr_slice_rdata),
    .ctr_slice_o     (ctr_slice_wdata),
    .ctr_we_o        (ctr_we)
  );

  // Counter slices
  aes_ctr_store u_store (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .load_i        (ctr_load_i),
    .load_value_i  (ctr_load_value_i),
    .slice_idx_i   (ctr_slice_idx),
    .slice_we_i    (ctr_we),
    .slice_wdata_i (ctr_slice_wdata),
    .slice_rdata_o (ctr_slice_rdata),
    .ctr_o         (ctr_o)
  );

endmodule

//--- test/tb_aes_ctr_check.sv
//////////////////////////////////////////////////////////////////////
// AES CTR testbench checker
// Predicts the counter from the DUT inputs, compares the DUT outputs
// every cycle and at the end of each case, counts the errors
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module tb_aes_ctr_check (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,

  // DUT inputs as driven by the stimulus
  input  logic [aes_ctr_pkg::IncrRailWidth-1:0] incr_rail_i,
  input  logic                                  mr_err_i,
  input  logic                                  ctr_load_i,
  input  logic [aes_ctr_pkg::CtrWidth-1:0]      ctr_load_value_i,

  // DUT outputs
  input  logic                                  ready_i,
  input  logic                                  alert_i,
  input  logic [aes_ctr_pkg::CtrWidth-1:0]      ctr_i,

  // End of case strobe with the value from the case file
  input  logic                                  case_chk_i,
  input  int                                    case_num_i,
  input  logic [aes_ctr_pkg::CtrWidth-1:0]      case_exp_i,

  // Error totals
  output int                                    mismatch_cnt_o,
  output int                                    protocol_cnt_o,
  output int                                    check_cnt_o
);

  import aes_ctr_pkg::*;

  // Accepted increment keeps ready low this long
  localparam int IncrCycles = 8;

  // Reference model
  logic [CtrWidth-1:0] exp_ctr   = '0;
  logic                ctr_known = 1'b1;
  logic                exp_alert = 1'b0;
  // Cycles left of a running increment
  int                  busy      = 0;

  int                  mismatch_cnt = 0;
  int                  protocol_cnt = 0;
  int                  check_cnt    = 0;

  assign mismatch_cnt_o = mismatch_cnt;
  assign protocol_cnt_o = protocol_cnt;
  assign check_cnt_o    = check_cnt;

  //////////////////////////////////////////////////////////////////////
  // Reporting
  //////////////////////////////////////////////////////////////////////

  task automatic expect_equal(input string name, input logic [CtrWidth-1:0] expected,
                              input logic [CtrWidth-1:0] actual);
    if (actual !== expected) begin
      $display("Mismatch %s at %0t: expected 0x%0h, actual 0x%0h",
               name, $time, expected, actual);
      mismatch_cnt++;
    end
  endtask

  task automatic protocol_error(input string msg);
    $display("At %0t: %s", $time, msg);
    protocol_cnt++;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Per-cycle checks
  //////////////////////////////////////////////////////////////////////

  // Outputs after the last edge against the model
  task automatic check_outputs();
    expect_equal("alert_o", exp_alert, alert_i);
    if (exp_alert) begin
      if (ready_i) begin
        protocol_error("ready_o is high while the alert is raised");
      end
      // Fault during an increment leaves a partial counter, take it once
      if (!ctr_known) begin
        exp_ctr   = ctr_i;
        ctr_known = 1'b1;
      end else begin
        expect_equal("ctr_o", exp_ctr, ctr_i);
      end
    end else if (busy > 0) begin
      if (ready_i) begin
        protocol_error($sformatf("ready_o high again %0d cycles after an accepted increment",
                                 IncrCycles - busy));
      end
    end else begin
      if (!ready_i) begin
        protocol_error("ready_o is low although no increment is running");
      end
      expect_equal("ctr_o", exp_ctr, ctr_i);
    end
  endtask

  // What the next edge does with the inputs seen now
  task automatic predict_next();
    logic fault;
    logic accept;
    int   busy_before;
    busy_before = busy;
    fault  = (incr_rail_i != '1 && incr_rail_i != '0) || mr_err_i;
    accept = !exp_alert && busy == 0 && incr_rail_i == '1 && !fault;
    if (busy > 0) begin
      busy--;
    end
    if (fault) begin
      // Slice writes in flight make the counter partly updated
      if (!exp_alert && busy_before > 0) begin
        ctr_known = 1'b0;
      end
      exp_alert = 1'b1;
      busy      = 0;
    end else if (accept) begin
      busy    = IncrCycles;
      // Wraps modulo 2**128
      exp_ctr = exp_ctr + 1'b1;
    end
    if (ctr_load_i) begin
      exp_ctr   = ctr_load_value_i;
      ctr_known = 1'b1;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Sampling at the falling edge, inputs and outputs both settled
  //////////////////////////////////////////////////////////////////////

  always @(negedge clk_i) begin
    if (!rst_ni) begin
      // Reset state of the DUT
      expect_equal("ready_o", 1'b1, ready_i);
      expect_equal("alert_o", 1'b0, alert_i);
      expect_equal("ctr_o", '0, ctr_i);
      exp_ctr   = '0;
      ctr_known = 1'b1;
      exp_alert = 1'b0;
      busy      = 0;
    end else begin
      check_outputs();
      predict_next();
      if (case_chk_i) begin
        // Counter against the case file
        check_cnt++;
        if (ctr_i !== case_exp_i) begin
          $display("Mismatch ctr_o in case %0d: expected 0x%0h, actual 0x%0h",
                   case_num_i, case_exp_i, ctr_i);
          mismatch_cnt++;
        end
      end
    end
  end

endmodule

//--- test/tb_aes_ctr.sv
//////////////////////////////////////////////////////////////////////
// AES CTR testbench top
// Clock, reset, case file reader, stimulus and watchdog around the
// counter increment block
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module tb_aes_ctr;

  import aes_ctr_pkg::*;

  // Operation codes of the case file
  localparam int OpLoad    = 0;
  localparam int OpIncr    = 1;
  localparam int OpBadRail = 2;
  localparam int OpMrErr   = 3;
  localparam int OpReset   = 4;

  // Timing
  localparam int ClkHalf       = 4;
  localparam int ResetCycles   = 3;
  localparam int CyclesPerCase = 20;
  localparam int CyclesMargin  = 100;

  localparam string CaseFile = "test/aes_ctr_cases.txt";

  // DUT signals
  logic                     clk;
  logic                     rst_n;
  logic [IncrRailWidth-1:0] incr_rail;
  logic                     mr_err;
  logic                     ctr_load;
  logic [CtrWidth-1:0]      ctr_load_value;
  logic                     ready;
  logic                     alert;
  logic [CtrWidth-1:0]      ctr;

  // Case hand-over to the checker
  logic                     case_chk;
  int                       case_num;
  logic [CtrWidth-1:0]      case_exp_val;

  // Cases from the file
  int                       case_op[$];
  logic [CtrWidth-1:0]      case_arg[$];
  logic [CtrWidth-1:0]      case_exp[$];

  // Run status
  int                       mismatch_cnt;
  int                       protocol_cnt;
  int                       check_cnt;
  int                       setup_errors = 0;
  int                       cycle_count  = 0;
  int                       cycle_limit  = 0;
  bit                       timed_out    = 1'b0;

  aes_ctr dut0 (
    .clk_i            (clk),
    .rst_ni           (rst_n),
    .incr_rail_i      (incr_rail),
    .mr_err_i         (mr_err),
    .ctr_load_i       (ctr_load),
    .ctr_load_value_i (ctr_load_value),
    .ready_o          (ready),
    .alert_o          (alert),
    .ctr_o            (ctr)
  );

  tb_aes_ctr_check u_check (
    .clk_i            (clk),
    .rst_ni           (rst_n),
    .incr_rail_i      (incr_rail),
    .mr_err_i         (mr_err),
    .ctr_load_i       (ctr_load),
    .ctr_load_value_i (ctr_load_value),
    .ready_i          (ready),
    .alert_i          (alert),
    .ctr_i            (ctr),
    .case_chk_i       (case_chk),
    .case_num_i       (case_num),
    .case_exp_i       (case_exp_val),
    .mismatch_cnt_o   (mismatch_cnt),
    .protocol_cnt_o   (protocol_cnt),
    .check_cnt_o      (check_cnt)
  );

  initial begin : clock_gen
    clk = 1'b0;
    forever #ClkHalf clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // Case file
  //////////////////////////////////////////////////////////////////////

  // Returns 0 when the file cannot be opened
  function automatic bit read_cases();
    int                  fd;
    int                  n;
    string               line;
    logic [63:0]         op_word;
    logic [CtrWidth-1:0] arg;
    logic [CtrWidth-1:0] expected;
    fd = $fopen(CaseFile, "r");
    if (fd == 0) begin
      $display("Cannot open the case file %s", CaseFile);
      return 1'b0;
    end
    while ($fgets(line, fd) != 0) begin
      // Blank lines and column notes
      if (line.len() < 2 || line.getc(0) == "#") begin
        continue;
      end
      n = $sscanf(line, "%s %h %h", op_word, arg, expected);
      if (n != 3) begin
        $display("Case file line is not op, operand, expected: %s", line);
        setup_errors++;
        continue;
      end
      case (op_word)
        "LOAD":    case_op.push_back(OpLoad);
        "INCR":    case_op.push_back(OpIncr);
        "BADRAIL": case_op.push_back(OpBadRail);
        "MRERR":   case_op.push_back(OpMrErr);
        "RESET":   case_op.push_back(OpReset);
        default: begin
          $display("Unknown operation in case file: %s", line);
          setup_errors++;
          continue;
        end
      endcase
      case_arg.push_back(arg);
      case_exp.push_back(expected);
    end
    $fclose(fd);
    return 1'b1;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  // Reset held over ResetCycles rising edges
  task automatic apply_reset();
    rst_n <= 1'b0;
    incr_rail <= IncrRailOff;
    mr_err <= 1'b0;
    ctr_load <= 1'b0;
    repeat (ResetCycles) @(posedge clk);
    rst_n <= 1'b1;
  endtask

  // Idle again, or locked in the error state
  task automatic wait_ready_or_alert();
    @(negedge clk);
    while (!(ready || alert)) begin
      @(negedge clk);
    end
  endtask

  task automatic run_case(input int op, input logic [CtrWidth-1:0] arg);
    wait_ready_or_alert();
    @(posedge clk);
    case (op)
      OpLoad: begin
        ctr_load <= 1'b1;
        ctr_load_value <= arg;
        @(posedge clk);
        ctr_load <= 1'b0;
      end
      OpIncr: begin
        // Operand gives extra cycles with the request still on
        incr_rail <= IncrRailOn;
        repeat (int'(arg[3:0]) + 1) @(posedge clk);
        incr_rail <= IncrRailOff;
      end
      OpBadRail: begin
        incr_rail <= arg[IncrRailWidth-1:0];
        @(posedge clk);
        incr_rail <= IncrRailOff;
      end
      OpMrErr: begin
        mr_err <= 1'b1;
        @(posedge clk);
        mr_err <= 1'b0;
      end
      default: begin
        apply_reset();
      end
    endcase
    wait_ready_or_alert();
  endtask

  // One-cycle strobe, checker samples it on the falling edge
  task automatic report_case(input int num, input logic [CtrWidth-1:0] expected);
    @(posedge clk);
    case_chk <= 1'b1;
    case_num <= num;
    case_exp_val <= expected;
    @(posedge clk);
    case_chk <= 1'b0;
  endtask

  task automatic finish_run();
    int total;
    total = mismatch_cnt + protocol_cnt + setup_errors + int'(timed_out);
    $display("Errors: %0d mismatch, %0d protocol, %0d setup, %0d timeout; %0d case checks",
             mismatch_cnt, protocol_cnt, setup_errors, int'(timed_out), check_cnt);
    if (total == 0 && check_cnt > 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  endtask

  initial begin : main
    int gap;
    void'($urandom(32'hc08d));
    rst_n          = 1'b0;
    incr_rail      = IncrRailOff;
    mr_err         = 1'b0;
    ctr_load       = 1'b0;
    ctr_load_value = '0;
    case_chk       = 1'b0;
    case_num       = 0;
    case_exp_val   = '0;
    if (!read_cases()) begin
      setup_errors++;
    end else begin
      cycle_limit = case_op.size() * CyclesPerCase + CyclesMargin;
      apply_reset();
      foreach (case_op[i]) begin
        // Idle gap of 0 to 3 cycles
        gap = $urandom % 4;
        repeat (gap) @(posedge clk);
        run_case(case_op[i], case_arg[i]);
        report_case(i, case_exp[i]);
      end
      @(negedge clk);
    end
    finish_run();
  end

  // Watchdog on the total cycle count
  initial begin : watchdog
    wait (cycle_limit != 0);
    while (cycle_count < cycle_limit) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout after %0d cycles, the cases did not complete", cycle_count);
    timed_out = 1'b1;
    finish_run();
  end

endmodule

//--- test/aes_ctr_cases.txt
# op     operand (hex)                     expected ctr_o after the case (hex)
# INCR operand: extra cycles the request stays on; BADRAIL operand: rail pattern
INCR     0                                 00000000000000000000000000000001
LOAD     0000000000000000000000000000ffff  0000000000000000000000000000ffff
INCR     0                                 00000000000000000000000000010000
LOAD     00000000000000000000ffffffffffff  00000000000000000000ffffffffffff
INCR     0                                 00000000000000000001000000000000
LOAD     0000ffffffffffffffffffffffffffff  0000ffffffffffffffffffffffffffff
INCR     0                                 00010000000000000000000000000000
LOAD     3a5c96e1f0d2b487c1e9a3f65b7d2c08  3a5c96e1f0d2b487c1e9a3f65b7d2c08
INCR     0                                 3a5c96e1f0d2b487c1e9a3f65b7d2c09
INCR     3                                 3a5c96e1f0d2b487c1e9a3f65b7d2c0a
LOAD     ffffffffffffffffffffffffffffffff  ffffffffffffffffffffffffffffffff
INCR     0                                 00000000000000000000000000000000
INCR     0                                 00000000000000000000000000000001
LOAD     0123456789abcdef0fedcba987654321  0123456789abcdef0fedcba987654321
BADRAIL  2                                 0123456789abcdef0fedcba987654321
INCR     0                                 0123456789abcdef0fedcba987654321
INCR     2                                 0123456789abcdef0fedcba987654321
RESET    0                                 00000000000000000000000000000000
LOAD     0000000000000000fffeffffffffffff  0000000000000000fffeffffffffffff
INCR     0                                 0000000000000000ffff000000000000
MRERR    0                                 0000000000000000ffff000000000000
INCR     0                                 0000000000000000ffff000000000000
RESET    0                                 00000000000000000000000000000000
INCR     0                                 00000000000000000000000000000001
BADRAIL  5                                 00000000000000000000000000000001
RESET    0                                 00000000000000000000000000000000
LOAD     fedcba98765432100123456789abcdef  fedcba98765432100123456789abcdef
INCR     0                                 fedcba98765432100123456789abcdf0

//--- src.f
design/aes_ctr_pkg.sv
design/aes_ctr_rail_dec.sv
design/aes_ctr_fsm.sv
design/aes_ctr_store.sv
design/aes_ctr.sv
test/tb_aes_ctr_check.sv
test/tb_aes_ctr.sv
